//--- Makefile
# Verilator build and run for the sprite testbench, run from the project root

VERILATOR ?= verilator
TOP       ?= sprite_tb
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# pass only if the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q '^Result: PASSED$$' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/display_timing.sv
// ****************************************
// no hsync or vsync, only coordinates, de and pulses
// all outputs low until the first clock after reset release
// ****************************************
`timescale 1ns/1ps

module display_timing (
    input  logic          clk_pix,
    input  logic          arst_n,
    display_timing_if.src tim
);
    import sprite_pkg::*;

    logic signed [cordw-1:0] sx_q;  // pixel counter
    logic signed [cordw-1:0] sy_q;  // line counter
    logic started;                  // first clock after reset seen
    logic sx_end;
    logic sy_end;

    assign sx_end = (sx_q == cordw'(h_total - 1));  // last pixel of a line
    assign sy_end = (sy_q == cordw'(v_total - 1));  // last line of a frame

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx_q    <= '0;
            sy_q    <= '0;
            started <= 1'b0;
        end else if (!started) begin
            started <= 1'b1;  // hold (0,0) one cycle, that cycle is the frame pulse
        end else if (sx_end) begin
            sx_q <= '0;
            if (sy_end) begin
                sy_q <= '0;
            end else begin
                sy_q <= sy_q + cordw'(1);
            end
        end else begin
            sx_q <= sx_q + cordw'(1);
        end
    end

    // counters straight out
    assign tim.sx = sx_q;
    assign tim.sy = sy_q;

    // levels and pulses, held low before the generator runs
    assign tim.de    = started && (sx_q < cordw'(h_res)) && (sy_q < cordw'(v_res));
    assign tim.line  = started && (sx_q == '0);
    assign tim.frame = started && (sx_q == '0) && (sy_q == '0);
endmodule

//--- design/display_timing_if.sv
// ****************************************
// plain levels and pulses, no handshake
// one pixel per clk_pix
// ****************************************
`timescale 1ns/1ps

interface display_timing_if;
    import sprite_pkg::*;

    logic signed [cordw-1:0] sx;  // horizontal position, 0..799
    logic signed [cordw-1:0] sy;  // vertical position, 0..524
    logic de;     // high in active area
    logic frame;  // one cycle at (0,0)
    logic line;   // one cycle at sx 0

    // timing generator side
    modport src (output sx, sy, de, frame, line);

    // consumers: sprite engine, painting
    modport snk (input sx, sy, de, frame, line);
endinterface

//--- design/letter_f.mem
// 8 rows top to bottom, 8 columns each, leftmost digit is column 0
11111110
11111110
11000000
11111100
11111100
11000000
11000000
00000000

//--- design/sprite_pkg.sv
// ****************************************
// 640x480 at one pixel per clk_pix, blanking kept in the totals
// sprite bitmap path is relative to the run directory
// ****************************************
package sprite_pkg;
    localparam int cordw = 16;  // signed screen coordinate width

    // active area
    localparam int h_res = 640;
    localparam int v_res = 480;

    // horizontal blanking, in pixels
    localparam int h_fp   = 16;
    localparam int h_sync = 96;
    localparam int h_bp   = 48;
    localparam int h_total = h_res + h_fp + h_sync + h_bp;  // 800

    // vertical blanking, in lines
    localparam int v_fp   = 10;
    localparam int v_sync = 2;
    localparam int v_bp   = 33;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;  // 525

    // sprite geometry
    localparam int spr_w     = 8;
    localparam int spr_h     = 8;
    localparam int spr_scale = 4;  // 32x32 on screen
    localparam int spr_cw    = $clog2(spr_w);      // column index width
    localparam int spr_rw    = $clog2(spr_h);      // row index width
    localparam int spr_sw    = $clog2(spr_scale);  // scale counter width
    localparam string spr_file = "design/letter_f.mem";

    // sprite engine states
    localparam logic [2:0] spr_idle  = 3'd0;
    localparam logic [2:0] spr_setup = 3'd1;  // fetch bitmap row
    localparam logic [2:0] spr_wait  = 3'd2;  // wait for x position
    localparam logic [2:0] spr_draw  = 3'd3;
    localparam logic [2:0] spr_done  = 3'd4;  // hold until next line

    // paint colours, 4 bits per channel, r in the top nibble
    localparam logic [11:0] col_spr = 12'hFC0;  // yellow
    localparam logic [11:0] col_bg  = 12'h137;  // blue
endpackage

//--- design/sprite_rom.sv
// ****************************************
// 8x8 one-bit sprite scaled by 4 with pix and drawing aligned to sx/sy
// x up to 607 and y up to 447 keep the sprite on screen
// leftmost file digit is bitmap column 0
// ****************************************
`timescale 1ns/1ps

module sprite_rom (
    input  logic                           clk_pix,
    input  logic                           arst_n,
    display_timing_if.snk                  tim,
    input  logic signed [sprite_pkg::cordw-1:0] sprx,
    input  logic signed [sprite_pkg::cordw-1:0] spry,
    output logic                           pix,
    output logic                           drawing
);
    import sprite_pkg::*;

    logic [0:spr_w-1] bmp [spr_h];  // index 0 = leftmost digit in the file
    logic [0:spr_w-1] row_r;        // bitmap row for the coming line

    logic signed [cordw-1:0] pos_x;  // position held for the frame
    logic signed [cordw-1:0] pos_y;
    logic signed [cordw-1:0] ny;     // line being prepared
    logic signed [cordw-1:0] wx;     // sx two before the left edge
    logic [2:0]        state;
    logic [spr_cw-1:0] col;     // bitmap column
    logic [spr_sw-1:0] cnt_x;   // horizontal repeat
    logic [spr_rw-1:0] row_y;   // bitmap row
    logic [spr_sw-1:0] cnt_y;   // vertical repeat
    logic setup_pt;
    logic frame_pt;
    logic in_rows;
    logic col_last;
    logic cnt_x_last;
    logic cnt_y_last;

    initial $readmemb(spr_file, bmp);

    // line setup 4 pixels before the line starts
    assign setup_pt = (tim.sx == cordw'(h_total - 4));
    assign frame_pt = setup_pt && (tim.sy == cordw'(v_total - 1));  // ahead of frame 0

    always_comb begin
        if (tim.sy == cordw'(v_total - 1)) begin
            ny = '0;  // wraps into the next frame
        end else begin
            ny = tim.sy + cordw'(1);
        end
        in_rows = (ny >= pos_y) && (ny < pos_y + cordw'(spr_h * spr_scale));
        // starts two pixels early and may fall in the previous line
        if (pos_x < cordw'(2)) begin
            wx = pos_x + cordw'(h_total - 2);
        end else begin
            wx = pos_x - cordw'(2);
        end
    end

    assign col_last   = (col == spr_cw'(spr_w - 1));
    assign cnt_x_last = (cnt_x == spr_sw'(spr_scale - 1));
    assign cnt_y_last = (cnt_y == spr_sw'(spr_scale - 1));

    // position only moves between frames
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (frame_pt || tim.frame) begin  // frame pulse also covers first frame
            pos_x <= sprx;
            pos_y <= spry;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == spr_setup) begin
            row_r <= bmp[row_y];  // row_y before its advance
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state   <= spr_idle;
            col     <= '0;
            cnt_x   <= '0;
            row_y   <= '0;
            cnt_y   <= '0;
            pix     <= 1'b0;
            drawing <= 1'b0;
        end else begin
            case (state)
                spr_setup: begin
                    pix     <= 1'b0;
                    drawing <= 1'b0;
                    if (in_rows) begin
                        state <= spr_wait;
                        if (cnt_y_last) begin  // row shown 4 times so step on
                            cnt_y <= '0;
                            row_y <= row_y + 1'b1;
                        end else begin
                            cnt_y <= cnt_y + 1'b1;
                        end
                    end else begin
                        state <= spr_idle;
                        row_y <= '0;  // ready for the top row next time
                        cnt_y <= '0;
                    end
                end
                spr_wait: begin
                    if (tim.sx == wx) begin
                        state <= spr_draw;
                        col   <= '0;
                        cnt_x <= '0;
                    end
                end
                spr_draw: begin
                    pix     <= row_r[col];  // shows one cycle later on its own sx
                    drawing <= 1'b1;
                    if (cnt_x_last) begin
                        cnt_x <= '0;
                        col   <= col + 1'b1;
                        if (col_last) begin
                            state <= spr_done;
                        end
                    end else begin
                        cnt_x <= cnt_x + 1'b1;
                    end
                end
                spr_done: begin
                    pix     <= 1'b0;
                    drawing <= 1'b0;  // held until the next setup point
                end
                default: ;  // idle until setup point
            endcase
            if (setup_pt) begin
                state <= spr_setup;  // every line whether or not the sprite is on it
            end
        end
    end
endmodule

//--- design/sprite_top.sv
// ****************************************
// yellow sprite over blue, SDL outputs one cycle after sx/sy
// position sampled once per frame
// ****************************************
`timescale 1ns/1ps

module sprite_top (
    input  logic                                clk_pix,
    input  logic                                arst_n,
    input  logic signed [sprite_pkg::cordw-1:0] sprx,
    input  logic signed [sprite_pkg::cordw-1:0] spry,
    output logic signed [sprite_pkg::cordw-1:0] sdl_sx,
    output logic signed [sprite_pkg::cordw-1:0] sdl_sy,
    output logic                                sdl_de,
    output logic                                sdl_frame,
    output logic [7:0]                          sdl_r,
    output logic [7:0]                          sdl_g,
    output logic [7:0]                          sdl_b
);
    import sprite_pkg::*;

    logic pix;
    logic drawing;
    logic [11:0] paint;  // 4-bit r, g, b

    display_timing_if tim ();

    display_timing timing_i (
        .clk_pix,
        .arst_n,
        .tim (tim)
    );

    sprite_rom sprite_i (
        .clk_pix,
        .arst_n,
        .tim (tim),
        .sprx,
        .spry,
        .pix,
        .drawing
    );

    // drawing alone is the box, pix the set bits inside it
    assign paint = (drawing && pix) ? col_spr : col_bg;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sdl_sx    <= '0;
            sdl_sy    <= '0;
            sdl_de    <= 1'b0;
            sdl_frame <= 1'b0;
            sdl_r     <= '0;
            sdl_g     <= '0;
            sdl_b     <= '0;
        end else begin
            sdl_sx    <= tim.sx;
            sdl_sy    <= tim.sy;
            sdl_de    <= tim.de;
            sdl_frame <= tim.frame;
            sdl_r     <= {2{paint[11:8]}};  // nibble repeated, F -> FF
            sdl_g     <= {2{paint[7:4]}};
            sdl_b     <= {2{paint[3:0]}};
        end
    end
endmodule

//--- files.f
design/sprite_pkg.sv
design/display_timing_if.sv
design/display_timing.sv
design/sprite_rom.sv
design/sprite_top.sv
verification/sprite_asserts.sv
verification/sprite_tb.sv

//--- verification/sprite_asserts.sv
// ****************************************
// checks hold from the first sdl_frame on
// fail_cnt counts failed assertions
// ****************************************
`timescale 1ns/1ps

module sprite_asserts (
    input logic                                clk_pix,
    input logic                                arst_n,
    input logic signed [sprite_pkg::cordw-1:0] sdl_sx,
    input logic signed [sprite_pkg::cordw-1:0] sdl_sy,
    input logic                                sdl_de,
    input logic                                sdl_frame,
    input logic [7:0]                          sdl_r,
    input logic [7:0]                          sdl_g,
    input logic [7:0]                          sdl_b
);
    import sprite_pkg::*;

    int fail_cnt = 0;
    logic running;        // first frame seen
    logic [11:0] nib_hi;  // upper nibbles r,g,b
    logic [11:0] nib_lo;

    assign nib_hi = {sdl_r[7:4], sdl_g[7:4], sdl_b[7:4]};
    assign nib_lo = {sdl_r[3:0], sdl_g[3:0], sdl_b[3:0]};

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else if (sdl_frame) begin
            running <= 1'b1;
        end
    end

    quiet_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (!running && !sdl_frame) |-> !sdl_de)
        else begin fail_cnt++; $error("data enable high before the first frame"); end

    origin_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        sdl_frame |-> (sdl_sx == '0 && sdl_sy == '0))
        else begin fail_cnt++; $error("frame pulse away from the origin"); end

    // de only inside 640x480
    de_area_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (running || sdl_frame) |->
            (sdl_de == (sdl_sx < cordw'(h_res) && sdl_sy < cordw'(v_res))))
        else begin fail_cnt++; $error("data enable does not match the active area"); end

    sx_step_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (running && sdl_sx != cordw'(h_total - 1)) |=> (sdl_sx == $past(sdl_sx) + cordw'(1)))
        else begin fail_cnt++; $error("sdl_sx did not step by one"); end

    sx_wrap_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (running && sdl_sx == cordw'(h_total - 1)) |=> (sdl_sx == '0))
        else begin fail_cnt++; $error("sdl_sx did not wrap to zero after 799"); end

    nibble_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        running |-> (nib_hi == nib_lo))
        else begin fail_cnt++; $error("colour channel nibbles differ"); end

    palette_a: assert property (@(posedge clk_pix) disable iff (!arst_n)
        running |-> (nib_hi == col_spr || nib_hi == col_bg))
        else begin fail_cnt++; $error("colour is neither sprite nor background"); end
endmodule

bind sprite_top sprite_asserts asserts_i (
    .clk_pix   (clk_pix),
    .arst_n    (arst_n),
    .sdl_sx    (sdl_sx),
    .sdl_sy    (sdl_sy),
    .sdl_de    (sdl_de),
    .sdl_frame (sdl_frame),
    .sdl_r     (sdl_r),
    .sdl_g     (sdl_g),
    .sdl_b     (sdl_b)
);

//--- verification/sprite_tb.sv
// ****************************************
// run from the project root to find design/letter_f.mem
// first frame uses y 1 since line 0 after reset gets no line setup
// ****************************************
`timescale 1ns/1ps

module sprite_tb;
    import sprite_pkg::*;

    localparam logic [31:0] seed = 32'h6a8f_bddd;
    localparam int n_frames = 3;
    localparam int clk_ns = 40;
    // three frames plus 10 percent
    localparam longint wd_ns = longint'(n_frames) * h_total * v_total * clk_ns * 11 / 10;

    logic clk_pix;
    logic arst_n;
    logic signed [cordw-1:0] sprx;
    logic signed [cordw-1:0] spry;
    logic signed [cordw-1:0] sdl_sx;
    logic signed [cordw-1:0] sdl_sy;
    logic sdl_de;
    logic sdl_frame;
    logic [7:0] sdl_r;
    logic [7:0] sdl_g;
    logic [7:0] sdl_b;

    logic [spr_w-1:0] ref_bmp [spr_h];  // MSB is column 0
    logic [31:0] rng;
    int shown_x;  // position of the frame now on screen
    int shown_y;
    int cur_x;    // pixel the outputs should describe
    int cur_y;
    int frames;
    int checks;
    int errors;

    sprite_top dut_i (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .sprx      (sprx),
        .spry      (spry),
        .sdl_sx    (sdl_sx),
        .sdl_sy    (sdl_sy),
        .sdl_de    (sdl_de),
        .sdl_frame (sdl_frame),
        .sdl_r     (sdl_r),
        .sdl_g     (sdl_g),
        .sdl_b     (sdl_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #(clk_ns / 2) clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 32x32 box at (px,py) with a 4x4 block per bitmap cell
    function automatic logic [11:0] expected_paint(input int x, input int y,
                                                   input int px, input int py);
        int dx;
        int dy;
        logic [spr_rw-1:0] r;
        logic [spr_cw-1:0] c;
        dx = x - px;
        dy = y - py;
        if (dx >= 0 && dx < spr_w * spr_scale && dy >= 0 && dy < spr_h * spr_scale) begin
            r = spr_rw'(dy / spr_scale);
            c = spr_cw'(spr_w - 1 - dx / spr_scale);
            if (ref_bmp[r][c]) begin
                return col_spr;
            end
        end
        return col_bg;
    endfunction

    task automatic compare(input string name, input int exp, input int act);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("[ERROR] %0d ns %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_quiet();
        compare("sdl_de", 0, int'(sdl_de));
        compare("sdl_frame", 0, int'(sdl_frame));
    endtask

    // raster order with 800 pixels per line and 525 lines
    task automatic advance_pixel();
        if (cur_x == h_total - 1) begin
            cur_x = 0;
            if (cur_y == v_total - 1) begin
                cur_y = 0;
            end else begin
                cur_y++;
            end
        end else begin
            cur_x++;
        end
    endtask

    task automatic check_pixel();
        logic [11:0] p;
        p = expected_paint(cur_x, cur_y, shown_x, shown_y);
        compare("sdl_sx", cur_x, int'(sdl_sx));
        compare("sdl_sy", cur_y, int'(sdl_sy));
        compare("sdl_r", int'(p[11:8]) * 17, int'(sdl_r));  // F gives FF
        compare("sdl_g", int'(p[7:4]) * 17, int'(sdl_g));
        compare("sdl_b", int'(p[3:0]) * 17, int'(sdl_b));
    endtask

    // x up to 607 and y up to 447 keep the whole sprite on screen
    task automatic pick_position();
        rng = lcg_next(rng);
        sprx = cordw'((rng >> 8) % 32'd608);
        rng = lcg_next(rng);
        spry = cordw'((rng >> 8) % 32'd448);
    endtask

    initial begin
        #(wd_ns);
        $display("timeout: run did not reach the end within %0d ns", wd_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        sprx = '0;       // left edge makes the engine start in the line before
        spry = cordw'(1);
        rng = seed;
        frames = 0;
        checks = 0;
        errors = 0;
        shown_x = 0;
        shown_y = 0;
        cur_x = 0;
        cur_y = 0;
        $readmemb("design/letter_f.mem", ref_bmp);
        repeat (5) begin
            @(negedge clk_pix);
            check_quiet();
        end
        arst_n = 1'b1;
        while (frames <= n_frames) begin
            @(negedge clk_pix);
            if (sdl_frame) begin
                frames++;
                shown_x = int'(sprx);  // value the DUT took at this frame
                shown_y = int'(spry);
                cur_x = 0;
                cur_y = 0;
                pick_position();  // applies from the next frame
            end else if (frames > 0) begin
                advance_pixel();
            end
            if (frames == 0) begin
                check_quiet();
            end else begin
                check_pixel();
            end
        end
        $display("checks %0d, compare errors %0d, assertion failures %0d",
                 checks, errors, dut_i.asserts_i.fail_cnt);
        if (errors == 0 && dut_i.asserts_i.fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule
